// File: run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module estimatorTb -f sim.f -o estimatorSim \
    && ./obj_dir/estimatorSim | tee /dev/stderr | grep -qF "SIMULATION PASSED" \
    && echo "Run passed" \
    || { echo "Run failed"; exit 1; }

// File: sim.f
+incdir+test
source/estimatorPkg.sv
source/estimatorIf.sv
source/controlDecode.sv
source/recursionExecute.sv
source/estimateResult.sv
source/batchEstimatorTop.sv
test/estimatorTb.sv

// File: source/batchEstimatorTop.sv
`timescale 1ns/1ps

module batchEstimatorTop (
    input  logic clkDS,
    input  logic rst,
    input  logic [estimatorPkg::CtrlBits-1:0] ctrl,
    input  logic ctrlValid,
    input  logic batchClear,
    output logic [estimatorPkg::OutWidth-1:0] estimate,
    output logic estimateValid
);

    contribIf contribBus ();
    stateIf stateBus ();

    // Control vector to per-channel contributions
    controlDecode decode (
        .clkDS(clkDS),
        .rst(rst),
        .ctrl(ctrl),
        .ctrlValid(ctrlValid),
        .batchClear(batchClear),
        .contrib(contribBus.src)
    );

    // Forward recursion
    recursionExecute execute (
        .clkDS(clkDS),
        .rst(rst),
        .contrib(contribBus.dst),
        .state(stateBus.src)
    );

    // Weighting, channel sum, output word
    estimateResult result (
        .clkDS(clkDS),
        .rst(rst),
        .state(stateBus.dst),
        .estimate(estimate),
        .estimateValid(estimateValid)
    );

endmodule

// File: source/controlDecode.sv
`timescale 1ns/1ps

module controlDecode (
    input  logic clkDS,
    input  logic rst,
    input  logic [estimatorPkg::CtrlBits-1:0] ctrl,
    input  logic ctrlValid,
    input  logic batchClear,
    contribIf.src contrib
);

    estimatorPkg::fixT sumRe [estimatorPkg::Channels];
    estimatorPkg::fixT sumIm [estimatorPkg::Channels];

    // Each bit adds or subtracts its table entry
    always_comb begin
        for (int ch = 0; ch < estimatorPkg::Channels; ch++) begin
            sumRe[ch] = '0;
            sumIm[ch] = '0;
            for (int b = 0; b < estimatorPkg::CtrlBits; b++) begin
                if (ctrl[b]) begin
                    sumRe[ch] = estimatorPkg::addFix(sumRe[ch], estimatorPkg::GammaRe[ch][b]);
                    sumIm[ch] = estimatorPkg::addFix(sumIm[ch], estimatorPkg::GammaIm[ch][b]);
                end else begin
                    sumRe[ch] = estimatorPkg::subFix(sumRe[ch], estimatorPkg::GammaRe[ch][b]);
                    sumIm[ch] = estimatorPkg::subFix(sumIm[ch], estimatorPkg::GammaIm[ch][b]);
                end
            end
        end
    end

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            contrib.valid <= 1'b0;
            contrib.clear <= 1'b0;
        end else begin
            contrib.valid <= ctrlValid;
            contrib.clear <= batchClear;
        end
    end

    always_ff @(posedge clkDS) begin
        if (ctrlValid) begin
            for (int ch = 0; ch < estimatorPkg::Channels; ch++) begin
                contrib.contribRe[ch] <= sumRe[ch];
                contrib.contribIm[ch] <= sumIm[ch];
            end
        end
    end

    ctrlKnown: assert property (
        @(posedge clkDS) disable iff (!rst)
        ctrlValid |-> !$isunknown(ctrl)
    );

endmodule

// File: source/estimateResult.sv
`timescale 1ns/1ps

module estimateResult (
    input  logic clkDS,
    input  logic rst,
    stateIf.dst state,
    output logic [estimatorPkg::OutWidth-1:0] estimate,
    output logic estimateValid
);

    estimatorPkg::fixT weighted [estimatorPkg::Channels];
    logic weightedValid;
    estimatorPkg::fixT chanSum;
    estimatorPkg::wideT scaled;
    estimatorPkg::wideT clamped;
    logic signed [estimatorPkg::OutWidth-1:0] outSat;

    // Stage one, real part of state * weight
    always_ff @(posedge clkDS) begin
        if (state.valid) begin
            for (int ch = 0; ch < estimatorPkg::Channels; ch++) begin
                weighted[ch] <= estimatorPkg::subFix(
                    estimatorPkg::mulFix(state.stateRe[ch], estimatorPkg::WeightRe[ch]),
                    estimatorPkg::mulFix(state.stateIm[ch], estimatorPkg::WeightIm[ch])
                );
            end
        end
    end

    // Channel sum, scale to the output word and clamp
    always_comb begin
        chanSum = '0;
        for (int ch = 0; ch < estimatorPkg::Channels; ch++) begin
            chanSum = estimatorPkg::addFix(chanSum, weighted[ch]);
        end
        scaled = estimatorPkg::wideT'(chanSum) >>> estimatorPkg::OutShift;
        if (scaled > estimatorPkg::OutMax) begin
            clamped = estimatorPkg::OutMax;
        end else if (scaled < estimatorPkg::OutMin) begin
            clamped = estimatorPkg::OutMin;
        end else begin
            clamped = scaled;
        end
        outSat = clamped[estimatorPkg::OutWidth-1:0];
    end

    // Stage two, offset binary out
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            weightedValid <= 1'b0;
            estimateValid <= 1'b0;
            estimate <= '0;
        end else begin
            weightedValid <= state.valid;
            estimateValid <= weightedValid;
            if (weightedValid) begin
                estimate <= {~outSat[estimatorPkg::OutWidth-1],
                             outSat[estimatorPkg::OutWidth-2:0]};
            end
        end
    end

    // A valid word must come from known state
    estimateKnown: assert property (
        @(posedge clkDS) disable iff (!rst)
        estimateValid |-> !$isunknown(estimate)
    );

endmodule

// File: source/estimatorIf.sv
`timescale 1ns/1ps

// Decode to execute, one complex contribution per channel
interface contribIf;

    logic valid;
    logic clear;
    estimatorPkg::fixT contribRe [estimatorPkg::Channels];
    estimatorPkg::fixT contribIm [estimatorPkg::Channels];

    modport src (
        output valid,
        output clear,
        output contribRe,
        output contribIm
    );

    modport dst (
        input valid,
        input clear,
        input contribRe,
        input contribIm
    );

endinterface

// Execute to result, recursion state per channel
interface stateIf;

    logic valid;
    estimatorPkg::fixT stateRe [estimatorPkg::Channels];
    estimatorPkg::fixT stateIm [estimatorPkg::Channels];

    modport src (
        output valid,
        output stateRe,
        output stateIm
    );

    modport dst (
        input valid,
        input stateRe,
        input stateIm
    );

endinterface

// File: source/estimatorPkg.sv
package estimatorPkg;

    localparam int Channels = 2;
    localparam int CtrlBits = 3;
    localparam int NInt = 3;
    localparam int NMant = 12;
    localparam int FixWidth = NInt + NMant + 1;
    localparam int OutWidth = 14;
    // Output word takes the top fraction bits of the channel sum
    localparam int OutShift = NMant + 1 - (OutWidth - 1);

    typedef logic signed [FixWidth-1:0] fixT;
    typedef logic signed [2*FixWidth-1:0] wideT;

    localparam wideT FixMax = (wideT'(1) <<< (FixWidth - 1)) - 1;
    localparam wideT FixMin = -FixMax - 1;
    localparam wideT OutMax = (wideT'(1) <<< (OutWidth - 1)) - 1;
    localparam wideT OutMin = -OutMax - 1;

    // Coefficients in units of 2^-NMant
    localparam fixT GammaRe [Channels][CtrlBits] = '{'{820, 615, 410}, '{-164, 369, 246}};
    localparam fixT GammaIm [Channels][CtrlBits] = '{'{205, -123, 328}, '{287, 205, -123}};

    // |lambda| below one keeps the recursion stable
    localparam fixT LambdaRe [Channels] = '{3686, 3277};
    localparam fixT LambdaIm [Channels] = '{819, -1638};

    localparam fixT WeightRe [Channels] = '{2048, 2560};
    localparam fixT WeightIm [Channels] = '{-4096, 1024};

    function automatic fixT satFix(input wideT x);
        fixT result;
        if (x > FixMax) begin
            result = FixMax[FixWidth-1:0];
        end else if (x < FixMin) begin
            result = FixMin[FixWidth-1:0];
        end else begin
            result = x[FixWidth-1:0];
        end
        return result;
    endfunction

    // Full product, floor shift back to the fixed-point grid
    function automatic fixT mulFix(input fixT a, input fixT b);
        wideT product;
        product = wideT'(a) * wideT'(b);
        return satFix(product >>> NMant);
    endfunction

    function automatic fixT addFix(input fixT a, input fixT b);
        return satFix(wideT'(a) + wideT'(b));
    endfunction

    function automatic fixT subFix(input fixT a, input fixT b);
        return satFix(wideT'(a) - wideT'(b));
    endfunction

endpackage

// File: source/recursionExecute.sv
`timescale 1ns/1ps

module recursionExecute (
    input  logic clkDS,
    input  logic rst,
    contribIf.dst contrib,
    stateIf.src state
);

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            state.valid <= 1'b0;
        end else begin
            state.valid <= contrib.valid;
        end
    end

    for (genvar ch = 0; ch < estimatorPkg::Channels; ch++) begin : gChannel
        estimatorPkg::fixT stateRe;
        estimatorPkg::fixT stateIm;
        estimatorPkg::fixT rotRe;
        estimatorPkg::fixT rotIm;
        estimatorPkg::fixT nextRe;
        estimatorPkg::fixT nextIm;

        // state * lambda, complex
        always_comb begin
            rotRe = estimatorPkg::subFix(
                estimatorPkg::mulFix(stateRe, estimatorPkg::LambdaRe[ch]),
                estimatorPkg::mulFix(stateIm, estimatorPkg::LambdaIm[ch])
            );
            rotIm = estimatorPkg::addFix(
                estimatorPkg::mulFix(stateRe, estimatorPkg::LambdaIm[ch]),
                estimatorPkg::mulFix(stateIm, estimatorPkg::LambdaRe[ch])
            );
        end

        // Clear drops the history, contribution only
        always_comb begin
            if (contrib.clear) begin
                nextRe = contrib.contribRe[ch];
                nextIm = contrib.contribIm[ch];
            end else begin
                nextRe = estimatorPkg::addFix(rotRe, contrib.contribRe[ch]);
                nextIm = estimatorPkg::addFix(rotIm, contrib.contribIm[ch]);
            end
        end

        // Holds while valid is low
        always_ff @(posedge clkDS or negedge rst) begin
            if (!rst) begin
                stateRe <= '0;
                stateIm <= '0;
            end else if (contrib.valid) begin
                stateRe <= nextRe;
                stateIm <= nextIm;
            end
        end

        assign state.stateRe[ch] = stateRe;
        assign state.stateIm[ch] = stateIm;
    end

    // A clear without a sample would be lost here
    clearWithValid: assert property (
        @(posedge clkDS) disable iff (!rst)
        contrib.clear |-> contrib.valid
    );

endmodule

// File: test/estimatorModel.svh
`ifndef ESTIMATOR_MODEL_SVH
`define ESTIMATOR_MODEL_SVH

// Clamp to a signed word of the given width
function automatic int clampSigned(input longint x, input int width);
    longint hi;
    longint lo;
    hi = (longint'(1) <<< (width - 1)) - 1;
    lo = -hi - 1;
    if (x > hi) begin
        return int'(hi);
    end else if (x < lo) begin
        return int'(lo);
    end
    return int'(x);
endfunction

// Full product, floor shift by the fraction bits, then clamp
function automatic int scaleProduct(input int a, input int b);
    longint full;
    full = longint'(a) * longint'(b);
    return clampSigned(full >>> estimatorPkg::NMant, estimatorPkg::FixWidth);
endfunction

// One bit adds its gamma entry, a zero bit subtracts it
function automatic int gammaSum(input int ch, input logic [estimatorPkg::CtrlBits-1:0] x,
        input bit imag);
    int acc;
    int entry;
    acc = 0;
    for (int b = 0; b < estimatorPkg::CtrlBits; b++) begin
        entry = imag ? int'(estimatorPkg::GammaIm[ch][b]) : int'(estimatorPkg::GammaRe[ch][b]);
        if (x[b]) begin
            acc = clampSigned(longint'(acc) + entry, estimatorPkg::FixWidth);
        end else begin
            acc = clampSigned(longint'(acc) - entry, estimatorPkg::FixWidth);
        end
    end
    return acc;
endfunction

// Real or imaginary part of state * lambda + contribution
function automatic int nextComponent(input int ch, input int sRe, input int sIm,
        input int c, input bit clear, input bit imag);
    int lRe;
    int lIm;
    int rot;
    lRe = int'(estimatorPkg::LambdaRe[ch]);
    lIm = int'(estimatorPkg::LambdaIm[ch]);
    if (imag) begin
        rot = clampSigned(longint'(scaleProduct(sRe, lIm)) + scaleProduct(sIm, lRe),
                          estimatorPkg::FixWidth);
    end else begin
        rot = clampSigned(longint'(scaleProduct(sRe, lRe)) - scaleProduct(sIm, lIm),
                          estimatorPkg::FixWidth);
    end
    return clear ? c : clampSigned(longint'(rot) + c, estimatorPkg::FixWidth);
endfunction

// Weighted channel sum as an offset-binary output word
function automatic logic [estimatorPkg::OutWidth-1:0] offsetEstimate(
        input int sRe [estimatorPkg::Channels], input int sIm [estimatorPkg::Channels]);
    int total;
    int part;
    int word;
    logic [estimatorPkg::OutWidth-1:0] bits;
    total = 0;
    for (int ch = 0; ch < estimatorPkg::Channels; ch++) begin
        part = clampSigned(
            longint'(scaleProduct(sRe[ch], int'(estimatorPkg::WeightRe[ch])))
            - scaleProduct(sIm[ch], int'(estimatorPkg::WeightIm[ch])),
            estimatorPkg::FixWidth);
        total = clampSigned(longint'(total) + part, estimatorPkg::FixWidth);
    end
    word = clampSigned(longint'(total) >>> (estimatorPkg::NMant + 1 - (estimatorPkg::OutWidth - 1)),
                       estimatorPkg::OutWidth);
    bits = word[estimatorPkg::OutWidth-1:0];
    bits[estimatorPkg::OutWidth-1] = ~bits[estimatorPkg::OutWidth-1];
    return bits;
endfunction

`endif

// File: test/estimatorTb.sv
`timescale 1ns/1ps

module estimatorTb;

    localparam int TableLen = 84;
    localparam int Period = 4;
    // Positive limit with the sign bit inverted
    localparam logic [estimatorPkg::OutWidth-1:0] FullScale = '1;

    logic clkDS;
    logic rst;
    logic [estimatorPkg::CtrlBits-1:0] ctrl;
    logic ctrlValid;
    logic batchClear;
    logic [estimatorPkg::OutWidth-1:0] estimate;
    logic estimateValid;

    logic tblValid [TableLen];
    logic tblClear [TableLen];
    logic [estimatorPkg::CtrlBits-1:0] tblCtrl [TableLen];
    logic [estimatorPkg::OutWidth-1:0] expected [$];
    logic tableReady;
    int seed;

    `include "estimatorModel.svh"

    batchEstimatorTop dut (
        .clkDS(clkDS),
        .rst(rst),
        .ctrl(ctrl),
        .ctrlValid(ctrlValid),
        .batchClear(batchClear),
        .estimate(estimate),
        .estimateValid(estimateValid)
    );

    initial begin
        clkDS = 1'b0;
        forever #(Period / 2) clkDS = ~clkDS;
    end

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] want,
            input string what);
        if (actual !== want) begin
            $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, actual, want);
            $display("SIMULATION FAILED");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    function automatic logic [estimatorPkg::CtrlBits-1:0] randomCtrl();
        int r;
        r = $random(seed);
        return r[estimatorPkg::CtrlBits-1:0];
    endfunction

    task automatic addEntry(inout int n, input logic v, input logic c,
            input logic [estimatorPkg::CtrlBits-1:0] x);
        tblValid[n] = v;
        tblClear[n] = c;
        tblCtrl[n] = x;
        n++;
    endtask

    task automatic buildTable();
        int n;
        n = 0;
        // Impulse, then all-zero control
        addEntry(n, 1'b1, 1'b1, 3'b101);
        repeat (8) addEntry(n, 1'b1, 1'b0, 3'b000);
        repeat (16) addEntry(n, 1'b1, 1'b0, randomCtrl());
        // Clear in the middle of a run
        addEntry(n, 1'b1, 1'b1, randomCtrl());
        repeat (6) addEntry(n, 1'b1, 1'b0, randomCtrl());
        // Gaps of two cycles
        for (int g = 0; g < 12; g++) begin
            addEntry(n, (g % 4 == 0) || (g % 4 == 3), 1'b0, randomCtrl());
        end
        repeat (40) addEntry(n, 1'b1, 1'b0, '1);
    endtask

    // Model state only moves on valid entries
    task automatic buildExpected();
        int sRe [estimatorPkg::Channels];
        int sIm [estimatorPkg::Channels];
        int cRe;
        int cIm;
        int nRe;
        for (int ch = 0; ch < estimatorPkg::Channels; ch++) begin
            sRe[ch] = 0;
            sIm[ch] = 0;
        end
        for (int i = 0; i < TableLen; i++) begin
            if (tblValid[i]) begin
                for (int ch = 0; ch < estimatorPkg::Channels; ch++) begin
                    cRe = gammaSum(ch, tblCtrl[i], 1'b0);
                    cIm = gammaSum(ch, tblCtrl[i], 1'b1);
                    nRe = nextComponent(ch, sRe[ch], sIm[ch], cRe, tblClear[i], 1'b0);
                    sIm[ch] = nextComponent(ch, sRe[ch], sIm[ch], cIm, tblClear[i], 1'b1);
                    sRe[ch] = nRe;
                end
                expected.push_back(offsetEstimate(sRe, sIm));
            end
        end
    endtask

    initial begin
        seed = 32'hd7e1;
        tableReady = 1'b0;
        rst = 1'b0;
        ctrl = '0;
        ctrlValid = 1'b0;
        batchClear = 1'b0;
        buildTable();
        buildExpected();
        tableReady = 1'b1;
        repeat (2) @(posedge clkDS);
        rst <= 1'b1;
        @(posedge clkDS);
        // Idle after reset, no ctrlValid yet
        checkValue(32'(estimateValid), 32'd0, "estimateValid after reset");
        checkValue(32'(estimate), 32'd0, "estimate after reset");
        for (int i = 0; i < TableLen; i++) begin
            @(posedge clkDS);
            ctrlValid <= tblValid[i];
            batchClear <= tblClear[i];
            ctrl <= tblCtrl[i];
        end
        @(posedge clkDS);
        ctrlValid <= 1'b0;
        batchClear <= 1'b0;
    end

    initial begin
        int checked;
        logic [3:0] validHistory;
        checked = 0;
        validHistory = '0;
        wait (tableReady && rst);
        while (checked < expected.size()) begin
            @(posedge clkDS);
            // estimateValid trails ctrlValid by four cycles
            checkValue(32'(estimateValid), 32'(validHistory[3]),
                       $sformatf("estimateValid before estimate %0d", checked));
            validHistory = {validHistory[2:0], ctrlValid};
            if (estimateValid) begin
                checkValue(32'(estimate), 32'(expected[checked]),
                           $sformatf("estimate %0d", checked));
                checked++;
            end
        end
        checkValue(32'(estimate), 32'(FullScale), "saturated estimate");
        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin
        #((TableLen + 20) * Period);
        $display("Timeout: estimateValid pulses stopped before all checks were done");
        $display("SIMULATION FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule
